//--- gpu_types_pkg.sv
// GPU core shared types

package gpu_types_pkg;

    // core geometry
    localparam int NUM_THREADS = 4;
    localparam int XLEN        = 32;
    localparam int NUM_WARPS   = 4;
    localparam int NW_BITS     = $clog2(NUM_WARPS);
    localparam int NUM_REGS    = 32;
    localparam int NR_BITS     = $clog2(NUM_REGS);
    localparam int UUID_BITS   = 16;

    // one finished instruction leaving an execution unit
    typedef struct packed {
        logic [UUID_BITS-1:0]             uuid;
        logic [NW_BITS-1:0]               wid;
        logic [NUM_THREADS-1:0]           tmask;
        logic [31:0]                      pc;
        logic                             wb;
        logic [NR_BITS-1:0]               rd;
        logic [NUM_THREADS-1:0][XLEN-1:0] data;
        // start and end of a multi-beat result packet
        logic                             sop;
        logic                             eop;
    } commit_rec_t;

    // value doubles as the arbiter input index
    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_SFU = 2'd2
    } ex_unit_e;

    localparam int NUM_EX_UNITS = 3;

endpackage

//--- retire_pkg.sv
// Retire counting types

package retire_pkg;

    import gpu_types_pkg::*;

    localparam int PERF_CTR_W   = 44;
    // wide enough for a full warp of active threads
    localparam int COMMIT_CNT_W = $clog2(NUM_THREADS + 1);

    typedef logic [PERF_CTR_W-1:0]   perf_ctr_t;
    typedef logic [COMMIT_CNT_W-1:0] commit_cnt_t;

    // number of active threads in a mask
    function automatic commit_cnt_t count_active(input logic [NUM_THREADS-1:0] tmask);
        commit_cnt_t cnt;
        cnt = '0;
        for (int t = 0; t < NUM_THREADS; t++) begin
            cnt = cnt + commit_cnt_t'(tmask[t]);
        end
        return cnt;
    endfunction

endpackage

//--- commit_lane_if.sv
// Commit lane interface

`timescale 1ns/1ps

interface commit_lane_if import gpu_types_pkg::*; ();

    logic        valid;
    logic        ready;
    commit_rec_t data;
    // unit that produced the record
    ex_unit_e    sel;

    // arbiter drives the chosen record
    modport arb (
        output valid,
        output data,
        output sel,
        input  ready
    );

    // retire block consumes it
    modport retire (
        input  valid,
        input  data,
        input  sel,
        output ready
    );

endinterface

//--- commit_lane_arb.sv
// Commit lane round-robin arbiter

`timescale 1ns/1ps

module commit_lane_arb import gpu_types_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [NUM_EX_UNITS-1:0]        in_valid,
    output logic [NUM_EX_UNITS-1:0]        in_ready,
    input  commit_rec_t [NUM_EX_UNITS-1:0] in_data,
    commit_lane_if.arb                     lane
);

    // unit granted most recently, lowest priority next
    ex_unit_e                last_sel;
    ex_unit_e                grant_sel;
    logic [NUM_EX_UNITS-1:0] grant;
    logic                    out_free;

    // output register takes a new record when empty or being drained
    assign out_free = !lane.valid || lane.ready;

    // walk from the farthest unit to the nearest one after last_sel,
    // so the nearest valid unit is the one that sticks
    always_comb begin
        int unit;
        unit      = 0;
        grant     = '0;
        grant_sel = last_sel;
        for (int off = NUM_EX_UNITS; off >= 1; off--) begin
            unit = (int'(last_sel) + off) % NUM_EX_UNITS;
            if (in_valid[unit]) begin
                grant       = '0;
                grant[unit] = 1'b1;
                grant_sel   = ex_unit_e'(unit);
            end
        end
        if (!out_free) begin
            grant = '0;
        end
    end

    // a unit is accepted exactly when it wins
    assign in_ready = grant;

    always_ff @(posedge clk) begin
        if (reset) begin
            lane.valid <= 1'b0;
            // ALU gets first pick after reset
            last_sel   <= EX_SFU;
        end else begin
            if (out_free) begin
                lane.valid <= |grant;
            end
            if (|grant) begin
                last_sel <= grant_sel;
            end
        end
    end

    // winning record and its source unit
    always_ff @(posedge clk) begin
        if (|grant) begin
            lane.data <= in_data[grant_sel];
            lane.sel  <= grant_sel;
        end
    end

    // at most one unit wins in a cycle
    a_grant_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(grant)
    ) else $error("lane arbiter granted more than one unit");

    // ready goes only to a unit that offers a result
    a_ready_needs_valid: assert property (
        @(posedge clk) disable iff (reset)
        (in_ready & ~in_valid) == '0
    ) else $error("lane arbiter gave ready to an idle unit");

endmodule

//--- commit_retire.sv
// Commit retire and writeback

`timescale 1ns/1ps

module commit_retire import gpu_types_pkg::*, retire_pkg::*; #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                                          clk,
    input  logic                                          reset,
    commit_lane_if.retire                                 lanes [ISSUE_WIDTH],
    output wire  [ISSUE_WIDTH-1:0]                        wb_valid,
    output wire  [ISSUE_WIDTH-1:0][UUID_BITS-1:0]         wb_uuid,
    output wire  [ISSUE_WIDTH-1:0][NW_BITS-1:0]           wb_wid,
    output wire  [ISSUE_WIDTH-1:0][31:0]                  wb_pc,
    output wire  [ISSUE_WIDTH-1:0][NUM_THREADS-1:0]       wb_tmask,
    output wire  [ISSUE_WIDTH-1:0][NR_BITS-1:0]           wb_rd,
    output wire  [ISSUE_WIDTH-1:0][NUM_THREADS-1:0][XLEN-1:0] wb_data,
    output wire  [ISSUE_WIDTH-1:0]                        wb_sop,
    output wire  [ISSUE_WIDTH-1:0]                        wb_eop,
    output logic [ISSUE_WIDTH-1:0]                        committed,
    output logic [ISSUE_WIDTH-1:0][NW_BITS-1:0]           committed_wid,
    output perf_ctr_t                                     instret,
    output logic [NUM_REGS-1:0][XLEN-1:0]                 sim_wb_value
);

    // holds the sum of all lane counts in one cycle
    localparam int SUM_W = COMMIT_CNT_W + $clog2(ISSUE_WIDTH);

    wire  [ISSUE_WIDTH-1:0]              lane_fire;
    wire  [ISSUE_WIDTH-1:0]              lane_eop;
    wire  [ISSUE_WIDTH-1:0][NW_BITS-1:0] lane_wid;
    wire  commit_cnt_t [ISSUE_WIDTH-1:0] lane_cnt;
    commit_cnt_t [ISSUE_WIDTH-1:0]       lane_cnt_r;
    logic [SUM_W-1:0]                    cnt_sum;
    logic [SUM_W-1:0]                    cnt_sum_r;

    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_lane
        // register file write port always accepts
        assign lanes[i].ready = 1'b1;

        assign lane_fire[i] = lanes[i].valid && lanes[i].ready;
        assign lane_eop[i]  = lanes[i].data.eop;
        assign lane_wid[i]  = lanes[i].data.wid;
        // idle lanes contribute no threads
        assign lane_cnt[i]  = count_active(lanes[i].data.tmask & {NUM_THREADS{lane_fire[i]}});

        // writeback port
        assign wb_valid[i] = lanes[i].valid && lanes[i].data.wb;
        assign wb_uuid[i]  = lanes[i].data.uuid;
        assign wb_wid[i]   = lanes[i].data.wid;
        assign wb_pc[i]    = lanes[i].data.pc;
        assign wb_tmask[i] = lanes[i].data.tmask;
        assign wb_rd[i]    = lanes[i].data.rd;
        assign wb_data[i]  = lanes[i].data.data;
        assign wb_sop[i]   = lanes[i].data.sop;
        assign wb_eop[i]   = lanes[i].data.eop;

        // scheduler only hears about packet ends it was really sent
        a_committed_after_eop: assert property (
            @(posedge clk) disable iff (reset)
            committed[i] |-> $past(lane_fire[i] && lane_eop[i])
        ) else $error("committed pulse on lane %0d without an eop commit", i);
    end

    // stage 2 adder across lanes
    always_comb begin
        cnt_sum = '0;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            cnt_sum = cnt_sum + SUM_W'(lane_cnt_r[i]);
        end
    end

    // count, sum and accumulate, one register each
    always_ff @(posedge clk) begin
        if (reset) begin
            lane_cnt_r <= '0;
            cnt_sum_r  <= '0;
            instret    <= '0;
        end else begin
            lane_cnt_r <= lane_cnt;
            cnt_sum_r  <= cnt_sum;
            instret    <= instret + PERF_CTR_W'(cnt_sum_r);
        end
    end

    // one-cycle pulse per eop commit
    always_ff @(posedge clk) begin
        if (reset) begin
            committed <= '0;
        end else begin
            committed <= lane_fire & lane_eop;
        end
    end

    always_ff @(posedge clk) begin
        committed_wid <= lane_wid;
    end

    // lane 0 register mirror, thread 0 value only
    always_ff @(posedge clk) begin
        if (wb_valid[0]) begin
            sim_wb_value[wb_rd[0]] <= wb_data[0][0];
        end
    end

    a_instret_monotonic: assert property (
        @(posedge clk) disable iff (reset)
        instret >= $past(instret)
    ) else $error("instret went backwards");

endmodule

//--- commit_stage.sv
// Commit stage top level

`timescale 1ns/1ps

module commit_stage import gpu_types_pkg::*, retire_pkg::*; #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                                          clk,
    input  logic                                          reset,
    // execution unit results, one per lane
    input  logic [ISSUE_WIDTH-1:0]                        alu_valid,
    output wire  [ISSUE_WIDTH-1:0]                        alu_ready,
    input  commit_rec_t [ISSUE_WIDTH-1:0]                 alu_data,
    input  logic [ISSUE_WIDTH-1:0]                        lsu_valid,
    output wire  [ISSUE_WIDTH-1:0]                        lsu_ready,
    input  commit_rec_t [ISSUE_WIDTH-1:0]                 lsu_data,
    input  logic [ISSUE_WIDTH-1:0]                        sfu_valid,
    output wire  [ISSUE_WIDTH-1:0]                        sfu_ready,
    input  commit_rec_t [ISSUE_WIDTH-1:0]                 sfu_data,
    // register file writeback
    output wire  [ISSUE_WIDTH-1:0]                        wb_valid,
    output wire  [ISSUE_WIDTH-1:0][UUID_BITS-1:0]         wb_uuid,
    output wire  [ISSUE_WIDTH-1:0][NW_BITS-1:0]           wb_wid,
    output wire  [ISSUE_WIDTH-1:0][31:0]                  wb_pc,
    output wire  [ISSUE_WIDTH-1:0][NUM_THREADS-1:0]       wb_tmask,
    output wire  [ISSUE_WIDTH-1:0][NR_BITS-1:0]           wb_rd,
    output wire  [ISSUE_WIDTH-1:0][NUM_THREADS-1:0][XLEN-1:0] wb_data,
    output wire  [ISSUE_WIDTH-1:0]                        wb_sop,
    output wire  [ISSUE_WIDTH-1:0]                        wb_eop,
    // scheduler and counters
    output wire  [ISSUE_WIDTH-1:0]                        committed,
    output wire  [ISSUE_WIDTH-1:0][NW_BITS-1:0]           committed_wid,
    output perf_ctr_t                                     instret,
    output wire  [NUM_REGS-1:0][XLEN-1:0]                 sim_wb_value
);

    commit_lane_if lanes [ISSUE_WIDTH] ();

    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_lane
        // unit results of this lane, indexed by ex_unit_e
        wire [NUM_EX_UNITS-1:0]        unit_valid;
        wire [NUM_EX_UNITS-1:0]        unit_ready;
        wire commit_rec_t [NUM_EX_UNITS-1:0] unit_data;

        assign unit_valid[EX_ALU] = alu_valid[i];
        assign unit_valid[EX_LSU] = lsu_valid[i];
        assign unit_valid[EX_SFU] = sfu_valid[i];
        assign unit_data[EX_ALU]  = alu_data[i];
        assign unit_data[EX_LSU]  = lsu_data[i];
        assign unit_data[EX_SFU]  = sfu_data[i];
        assign alu_ready[i]       = unit_ready[EX_ALU];
        assign lsu_ready[i]       = unit_ready[EX_LSU];
        assign sfu_ready[i]       = unit_ready[EX_SFU];

        commit_lane_arb i_arb (
            .clk      (clk),
            .reset    (reset),
            .in_valid (unit_valid),
            .in_ready (unit_ready),
            .in_data  (unit_data),
            .lane     (lanes[i])
        );
    end

    commit_retire #(
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) i_retire (
        .clk           (clk),
        .reset         (reset),
        .lanes         (lanes),
        .wb_valid      (wb_valid),
        .wb_uuid       (wb_uuid),
        .wb_wid        (wb_wid),
        .wb_pc         (wb_pc),
        .wb_tmask      (wb_tmask),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .wb_sop        (wb_sop),
        .wb_eop        (wb_eop),
        .committed     (committed),
        .committed_wid (committed_wid),
        .instret       (instret),
        .sim_wb_value  (sim_wb_value)
    );

endmodule

//--- commit_stage_tb.sv
// Commit stage testbench

`timescale 1ns/1ps

module commit_stage_tb import gpu_types_pkg::*, retire_pkg::*; ();

    localparam int ISSUE_WIDTH    = 2;
    localparam int ACCEPT_TIMEOUT = 20;
    // stimulus modes
    localparam int MODE_IDLE   = 0;
    localparam int MODE_SPARSE = 1;
    localparam int MODE_RANDOM = 2;
    localparam int MODE_BUSY   = 3;

    logic clk = 1'b0;
    logic reset;

    // unit side of each lane, indexed by ex_unit_e
    logic [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0] vld;
    logic [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0] rdy;
    logic [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0] acc;
    logic [ISSUE_WIDTH-1:0][NUM_EX_UNITS-1:0] acc_q;
    logic [ISSUE_WIDTH-1:0]                   busy;
    commit_rec_t                              rec [ISSUE_WIDTH][NUM_EX_UNITS];
    int                                       wait_cnt [ISSUE_WIDTH][NUM_EX_UNITS];

    logic [ISSUE_WIDTH-1:0]                        alu_valid;
    wire  [ISSUE_WIDTH-1:0]                        alu_ready;
    commit_rec_t [ISSUE_WIDTH-1:0]                 alu_data;
    logic [ISSUE_WIDTH-1:0]                        lsu_valid;
    wire  [ISSUE_WIDTH-1:0]                        lsu_ready;
    commit_rec_t [ISSUE_WIDTH-1:0]                 lsu_data;
    logic [ISSUE_WIDTH-1:0]                        sfu_valid;
    wire  [ISSUE_WIDTH-1:0]                        sfu_ready;
    commit_rec_t [ISSUE_WIDTH-1:0]                 sfu_data;
    wire  [ISSUE_WIDTH-1:0]                        wb_valid;
    wire  [ISSUE_WIDTH-1:0][UUID_BITS-1:0]         wb_uuid;
    wire  [ISSUE_WIDTH-1:0][NW_BITS-1:0]           wb_wid;
    wire  [ISSUE_WIDTH-1:0][31:0]                  wb_pc;
    wire  [ISSUE_WIDTH-1:0][NUM_THREADS-1:0]       wb_tmask;
    wire  [ISSUE_WIDTH-1:0][NR_BITS-1:0]           wb_rd;
    wire  [ISSUE_WIDTH-1:0][NUM_THREADS-1:0][XLEN-1:0] wb_data;
    wire  [ISSUE_WIDTH-1:0]                        wb_sop;
    wire  [ISSUE_WIDTH-1:0]                        wb_eop;
    wire  [ISSUE_WIDTH-1:0]                        committed;
    wire  [ISSUE_WIDTH-1:0][NW_BITS-1:0]           committed_wid;
    perf_ctr_t                                     instret;
    wire  [NUM_REGS-1:0][XLEN-1:0]                 sim_wb_value;

    // reference model state
    commit_rec_t                         model_q [ISSUE_WIDTH][$];
    logic [ISSUE_WIDTH-1:0]              exp_valid;
    commit_rec_t                         exp_rec [ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0]              exp_commit;
    logic [ISSUE_WIDTH-1:0][NW_BITS-1:0] exp_cwid;
    perf_ctr_t                           exp_acc = '0;
    logic [XLEN-1:0]                     exp_regs [NUM_REGS];
    logic [NUM_REGS-1:0]                 exp_written;

    logic [31:0]          lfsr;
    logic [UUID_BITS-1:0] next_uuid = '0;
    int                   commits = 0;
    int                   mismatches = 0;
    int                   timeouts = 0;

    always #50 clk = ~clk;

    commit_stage #(
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) i_dut (
        .clk           (clk),
        .reset         (reset),
        .alu_valid     (alu_valid),
        .alu_ready     (alu_ready),
        .alu_data      (alu_data),
        .lsu_valid     (lsu_valid),
        .lsu_ready     (lsu_ready),
        .lsu_data      (lsu_data),
        .sfu_valid     (sfu_valid),
        .sfu_ready     (sfu_ready),
        .sfu_data      (sfu_data),
        .wb_valid      (wb_valid),
        .wb_uuid       (wb_uuid),
        .wb_wid        (wb_wid),
        .wb_pc         (wb_pc),
        .wb_tmask      (wb_tmask),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .wb_sop        (wb_sop),
        .wb_eop        (wb_eop),
        .committed     (committed),
        .committed_wid (committed_wid),
        .instret       (instret),
        .sim_wb_value  (sim_wb_value)
    );

    for (genvar l = 0; l < ISSUE_WIDTH; l++) begin : g_map
        assign alu_valid[l]   = vld[l][EX_ALU];
        assign lsu_valid[l]   = vld[l][EX_LSU];
        assign sfu_valid[l]   = vld[l][EX_SFU];
        assign alu_data[l]    = rec[l][EX_ALU];
        assign lsu_data[l]    = rec[l][EX_LSU];
        assign sfu_data[l]    = rec[l][EX_SFU];
        assign rdy[l][EX_ALU] = alu_ready[l];
        assign rdy[l][EX_LSU] = lsu_ready[l];
        assign rdy[l][EX_SFU] = sfu_ready[l];
        assign acc[l]         = vld[l] & rdy[l];
        assign busy[l]        = &vld[l];
    end

    // units accepted at the last edge
    always @(posedge clk) begin
        acc_q <= acc;
    end

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic commit_rec_t make_record();
        commit_rec_t r;
        r.uuid  = next_uuid;
        r.wid   = NW_BITS'(take_bits(NW_BITS));
        r.tmask = NUM_THREADS'(take_bits(NUM_THREADS));
        r.pc    = 32'h8000_0000 + {14'd0, next_uuid, 2'b00};
        r.wb    = take_bits(1) == 32'd1;
        r.rd    = NR_BITS'(take_bits(NR_BITS));
        for (int t = 0; t < NUM_THREADS; t++) begin
            r.data[t] = take_bits(XLEN);
        end
        r.sop     = take_bits(1) == 32'd1;
        r.eop     = take_bits(1) == 32'd1;
        next_uuid = next_uuid + 16'd1;
        return r;
    endfunction

    // a record accepted at one edge sits in the lane register until the next,
    // then it retires into the counters, the pulses and the mirror
    always @(posedge clk) begin
        perf_ctr_t   sum;
        commit_rec_t done_rec;
        sum = exp_acc;
        if (reset) begin
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                model_q[l].delete();
            end
            exp_valid   <= '0;
            exp_commit  <= '0;
            exp_written <= '0;
            exp_acc     <= '0;
        end else begin
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                exp_commit[l] <= 1'b0;
                if (model_q[l].size() > 0) begin
                    done_rec      = model_q[l].pop_front();
                    commits       = commits + 1;
                    sum           = sum + PERF_CTR_W'($countones(done_rec.tmask));
                    exp_commit[l] <= done_rec.eop;
                    exp_cwid[l]   <= done_rec.wid;
                    if (l == 0 && done_rec.wb) begin
                        exp_regs[done_rec.rd]    <= done_rec.data[0];
                        exp_written[done_rec.rd] <= 1'b1;
                    end
                end
                for (int u = 0; u < NUM_EX_UNITS; u++) begin
                    if (acc[l][u]) begin
                        model_q[l].push_back(rec[l][u]);
                    end
                end
                exp_valid[l] <= model_q[l].size() > 0;
                if (model_q[l].size() > 0) begin
                    exp_rec[l] <= model_q[l][0];
                end
            end
            exp_acc <= sum;
        end
    end

    a_reset_state: assert property (@(posedge clk)
        $fell(reset) |-> instret == '0 && wb_valid == '0 && committed == '0
            && (alu_ready | lsu_ready | sfu_ready) == '0
    ) else begin
        mismatches = mismatches + 1;
        $display("mismatch at %0t: outputs not idle after reset", $time);
    end

    // three register stages between commit and counter
    a_instret: assert property (@(posedge clk) disable iff (reset)
        instret == $past(exp_acc, 2)
    ) else begin
        mismatches = mismatches + 1;
        $display("mismatch at %0t: instret differs from the model sum", $time);
    end

    for (genvar l = 0; l < ISSUE_WIDTH; l++) begin : g_chk
        a_one_accept: assert property (@(posedge clk) disable iff (reset)
            $onehot0(acc[l])
        ) else begin
            mismatches = mismatches + 1;
            $display("mismatch at %0t: lane %0d accepted several units", $time, l);
        end

        a_wb_valid: assert property (@(posedge clk) disable iff (reset)
            wb_valid[l] == (exp_valid[l] && exp_rec[l].wb)
        ) else begin
            mismatches = mismatches + 1;
            $display("mismatch at %0t: lane %0d wb_valid", $time, l);
        end

        a_wb_fields: assert property (@(posedge clk) disable iff (reset)
            exp_valid[l] |-> {wb_uuid[l], wb_wid[l], wb_pc[l], wb_tmask[l], wb_rd[l],
                              wb_data[l], wb_sop[l], wb_eop[l]}
                          == {exp_rec[l].uuid, exp_rec[l].wid, exp_rec[l].pc,
                              exp_rec[l].tmask, exp_rec[l].rd, exp_rec[l].data,
                              exp_rec[l].sop, exp_rec[l].eop}
        ) else begin
            mismatches = mismatches + 1;
            $display("mismatch at %0t: lane %0d writeback fields", $time, l);
        end

        a_committed: assert property (@(posedge clk) disable iff (reset)
            committed[l] == exp_commit[l]
                && (!exp_commit[l] || committed_wid[l] == exp_cwid[l])
        ) else begin
            mismatches = mismatches + 1;
            $display("mismatch at %0t: lane %0d committed pulse or wid", $time, l);
        end

        for (genvar u = 0; u < NUM_EX_UNITS; u++) begin : g_unit
            // round robin serves each of three busy units within three cycles
            a_fair: assert property (@(posedge clk) disable iff (reset)
                busy[l] && $past(busy[l]) && $past(busy[l], 2)
                    |-> acc[l][u] || $past(acc[l][u]) || $past(acc[l][u], 2)
            ) else begin
                mismatches = mismatches + 1;
                $display("mismatch at %0t: lane %0d unit %0d starved", $time, l, u);
            end
        end
    end

    for (genvar r = 0; r < NUM_REGS; r++) begin : g_mirror
        a_mirror: assert property (@(posedge clk) disable iff (reset)
            exp_written[r] |-> sim_wb_value[r] == exp_regs[r]
        ) else begin
            mismatches = mismatches + 1;
            $display("mismatch at %0t: register mirror entry %0d", $time, r);
        end
    end

    // one stimulus step per cycle; a valid unit holds its record until accepted
    task automatic run_cycles(input int n, input int mode);
        bit start;
        for (int c = 0; c < n && timeouts == 0; c++) begin
            @(posedge clk);
            #1;
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                for (int u = 0; u < NUM_EX_UNITS; u++) begin
                    if (acc_q[l][u]) begin
                        vld[l][u] = 1'b0;
                    end
                    if (vld[l][u]) begin
                        wait_cnt[l][u] = wait_cnt[l][u] + 1;
                        if (wait_cnt[l][u] > ACCEPT_TIMEOUT) begin
                            timeouts = timeouts + 1;
                            $display("timeout: lane %0d unit %0d was not accepted within %0d cycles",
                                     l, u, ACCEPT_TIMEOUT);
                        end
                    end else begin
                        start = (mode == MODE_BUSY)
                             || (mode == MODE_RANDOM && take_bits(2) != 32'd0)
                             || (mode == MODE_SPARSE && take_bits(3) == 32'd0);
                        if (start) begin
                            vld[l][u]      = 1'b1;
                            rec[l][u]      = make_record();
                            wait_cnt[l][u] = 0;
                        end
                    end
                end
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        vld   = '0;
        lfsr  = 32'h1533;
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            for (int u = 0; u < NUM_EX_UNITS; u++) begin
                rec[l][u]      = '0;
                wait_cnt[l][u] = 0;
            end
        end
        for (int c = 0; c < 10; c++) begin
            @(posedge clk);
        end
        #1;
        reset = 1'b0;
        run_cycles(150, MODE_SPARSE);
        run_cycles(250, MODE_RANDOM);
        // every unit stays valid
        run_cycles(60, MODE_BUSY);
        run_cycles(250, MODE_RANDOM);
        run_cycles(12, MODE_IDLE);
        $display("summary: %0d commits, %0d mismatches, %0d timeouts",
                 commits, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- sources.f
gpu_types_pkg.sv
retire_pkg.sv
commit_lane_if.sv
commit_lane_arb.sv
commit_retire.sv
commit_stage.sv
commit_stage_tb.sv

//--- run.sh
#!/bin/sh
# build and run the commit stage testbench, then check the log
rm -f sim.log
verilator --binary --assert --top-module commit_stage_tb -f sources.f -o commit_stage_sim \
    && ./obj_dir/commit_stage_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Verification passed" sim.log 2>/dev/null && echo "run: simulation passed" || {
    echo "run: simulation failed"
    exit 1
}
